//--- realign_line_ctrl.sv
/*
 * realign_line_ctrl
 * accepts one line command at a time and counts consumed input beats
 * drives first, last and rotation control for each beat of the line
 */

`default_nettype none

module realign_line_ctrl (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       cmd_valid_i,
  input  realign_pkg::realign_cmd_t  cmd_i,
  output logic                       cmd_ready_o,
  input  logic                       beat_valid_i,
  input  logic                       beat_ready_i,
  input  logic                       line_done_i,
  output logic                       line_active_o,
  output realign_pkg::realign_ctrl_t ctrl_o
);

  import realign_pkg::*;

  realign_cmd_t       cmd_q;
  logic               active_q;
  logic [LEN_WIDTH:0] beat_count_q;
  logic [LEN_WIDTH:0] last_index_q;
  logic [LEN_WIDTH:0] last_index;
  logic               cmd_accept;
  logic               beat_accept;
  logic               cmd_misaligned;

  assign cmd_ready_o = ~active_q;
  assign cmd_accept  = cmd_valid_i & cmd_ready_o;
  assign beat_accept = beat_valid_i & beat_ready_i;

  // a misaligned line spans one extra input beat
  assign cmd_misaligned = (cmd_i.offset != '0);
  assign last_index = cmd_misaligned ? {1'b0, cmd_i.line_length}
                                     : {1'b0, cmd_i.line_length} - 1'b1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q     <= 1'b0;
      cmd_q        <= '0;
      beat_count_q <= '0;
      last_index_q <= '0;
    end else begin
      if (beat_accept) begin
        beat_count_q <= beat_count_q + 1'b1;
      end
      if (cmd_accept) begin
        cmd_q        <= cmd_i;
        last_index_q <= last_index;
        beat_count_q <= '0;
        active_q     <= 1'b1;
      end else if (line_done_i) begin
        // output side has handed over the last word
        active_q <= 1'b0;
      end
    end
  end

  assign line_active_o = active_q;

  always_comb begin
    ctrl_o.first    = active_q & (beat_count_q == '0);
    ctrl_o.last     = active_q & (beat_count_q == last_index_q);
    ctrl_o.realign  = (cmd_q.offset != '0);
    ctrl_o.rotation = cmd_q.offset;
  end

endmodule

`default_nettype wire

//--- realign_pkg.sv
/*
 * shared definitions for the source realign datapath
 * word, strobe, FIFO and line field widths
 * stream beat, line command and per-beat control structs
 */

`default_nettype none

package realign_pkg;

  // datapath geometry
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  // input FIFO, depth kept a power of two
  localparam int FIFO_DEPTH = 4;
  localparam int PTR_WIDTH  = $clog2(FIFO_DEPTH);

  // line command fields
  localparam int LEN_WIDTH = 8;
  localparam int OFS_WIDTH = $clog2(STRB_WIDTH);

  // one word beat on any stream path
  // last only carries meaning on the output side
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic                  last;
  } stream_beat_t;

  // byte offset of the line start and length in words
  typedef struct packed {
    logic [OFS_WIDTH-1:0] offset;
    logic [LEN_WIDTH-1:0] line_length;
  } realign_cmd_t;

  // per-beat control towards the realigner
  typedef struct packed {
    logic                 first;
    logic                 last;
    logic                 realign;
    logic [OFS_WIDTH-1:0] rotation;
  } realign_ctrl_t;

endpackage

`default_nettype wire

//--- realign_tb.sv
/*
 * testbench for realign_top
 * LCG stimulus for line commands, input beats, strobe holes and stalls
 * reference model of the byte-index rule, output compare, watchdog
 */

`default_nettype none

module realign_tb;

  import realign_pkg::*;

  logic         clk_i = 1'b0;
  logic         reset_i;
  logic         cmd_valid_i;
  realign_cmd_t cmd_i;
  logic         cmd_ready_o;
  logic         in_valid_i;
  stream_beat_t in_beat_i;
  logic         in_ready_o;
  logic         out_valid_o;
  stream_beat_t out_beat_o;
  logic         out_ready_i;

  // bytes of the current line, up to 17 input beats
  logic [7:0]   src_byte [17*STRB_WIDTH];
  logic         src_strb [17*STRB_WIDTH];
  stream_beat_t exp_q [$];
  stream_beat_t popped_beat;
  int unsigned  stim_state;
  int unsigned  ready_state;
  bit           stall_enable;
  bit           cmd_check_due = 1'b0;
  int           cmp_errors = 0;
  int           beats_checked = 0;
  int           main_errors;
  int           total_lines;
  int           test_lines;
  int           test_err_base;
  int           cycle_count;

  realign_top realign_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .cmd_ready_o (cmd_ready_o),
    .in_valid_i  (in_valid_i),
    .in_beat_i   (in_beat_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_beat_o  (out_beat_o),
    .out_ready_i (out_ready_i)
  );

  always #10 clk_i = ~clk_i;

  function automatic int unsigned lcg_next(inout int unsigned state);
    state = state * 32'd1103515245 + 32'd12345;
    return state >> 16;
  endfunction

  function automatic int rand_below(input int n);
    return int'(lcg_next(stim_state) % n);
  endfunction

  // output byte b of word j is source byte ofs + 4j + b
  function automatic stream_beat_t expected_beat(input int ofs, input int len, input int j);
    stream_beat_t exp_beat;
    int b;
    int idx;
    exp_beat = '0;
    for (b = 0; b < STRB_WIDTH; b++) begin
      idx = ofs + STRB_WIDTH * j + b;
      exp_beat.data[8*b +: 8] = src_byte[idx];
      exp_beat.strb[b] = src_strb[idx];
    end
    exp_beat.last = (j == len - 1);
    return exp_beat;
  endfunction

  task automatic check_beat(input stream_beat_t got, input stream_beat_t exp, inout int errors);
    beats_checked++;
    if (got !== exp) begin
      errors++;
      $display("** Error at time %0t: output data %h strb %b last %b, expected %h %b %b",
               $time, got.data, got.strb, got.last, exp.data, exp.strb, exp.last);
    end
  endtask

  task automatic check_cmd_ready(input logic got, input string when, inout int errors);
    if (got !== 1'b1) begin
      errors++;
      $display("** Error at time %0t: cmd_ready_o is %b %s, expected 1", $time, got, when);
    end
  endtask

  task automatic check_out_valid(input logic got, inout int errors);
    if (got !== 1'b0) begin
      errors++;
      $display("** Error at time %0t: out_valid_o is %b after reset, expected 0", $time, got);
    end
  endtask

  // command, then input beats, at most max_beats of them
  task automatic drive_line(input int ofs, input int len, input bit holes, input bit gaps,
                            input int max_beats);
    stream_beat_t beat;
    int nbeats;
    int k;
    int b;
    nbeats = (ofs == 0) ? len : len + 1;
    for (k = 0; k < nbeats * STRB_WIDTH; k++) begin
      src_byte[k] = 8'(lcg_next(stim_state));
      src_strb[k] = holes ? (rand_below(4) != 0) : 1'b1;
    end
    for (k = 0; k < len; k++) begin
      exp_q.push_back(expected_beat(ofs, len, k));
    end
    total_lines++;
    test_lines++;
    @(negedge clk_i);
    cmd_valid_i = 1'b1;
    cmd_i.offset = OFS_WIDTH'(ofs);
    cmd_i.line_length = LEN_WIDTH'(len);
    @(posedge clk_i);
    while (!cmd_ready_o) @(posedge clk_i);
    for (k = 0; k < nbeats && k < max_beats; k++) begin
      @(negedge clk_i);
      cmd_valid_i = 1'b0;
      if (gaps && rand_below(4) == 0) begin
        in_valid_i = 1'b0;
        repeat (1 + rand_below(3)) @(negedge clk_i);
      end
      beat = '0;
      for (b = 0; b < STRB_WIDTH; b++) begin
        beat.data[8*b +: 8] = src_byte[STRB_WIDTH * k + b];
        beat.strb[b] = src_strb[STRB_WIDTH * k + b];
      end
      in_valid_i = 1'b1;
      in_beat_i = beat;
      @(posedge clk_i);
      while (!in_ready_o) @(posedge clk_i);
    end
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
    in_valid_i = 1'b0;
  endtask

  task automatic report_test(input string name);
    while (exp_q.size() != 0) @(posedge clk_i);
    // leaves room for the command ready check after the last beat
    repeat (2) @(posedge clk_i);
    $display("test %s: %0d lines, %0d errors", name, test_lines,
             cmp_errors + main_errors - test_err_base);
    test_lines = 0;
    test_err_base = cmp_errors + main_errors;
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      exp_q.delete();
      cmd_check_due = 1'b0;
    end else begin
      if (cmd_check_due) begin
        check_cmd_ready(cmd_ready_o, "after the last beat", cmp_errors);
        cmd_check_due = 1'b0;
      end
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          cmp_errors++;
          $display("unexpected output beat at time %0t while no beat was pending", $time);
        end else begin
          popped_beat = exp_q.pop_front();
          check_beat(out_beat_o, popped_beat, cmp_errors);
          cmd_check_due = popped_beat.last;
        end
      end
    end
  end

  initial begin : ready_stalls
    ready_state = 32'd66969;
    out_ready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      if (stall_enable) begin
        out_ready_i = (lcg_next(ready_state) % 2) != 0;
      end else begin
        out_ready_i = 1'b1;
      end
    end
  end

  // 40 lines of up to 17 beats at 8 cycles each, plus margin
  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < 40 * 17 * 8 + 500) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_count);
    $display("Something failed");
    $finish;
  end

  initial begin : stimulus
    int i;
    int ofs;
    reset_i = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_i = '0;
    in_valid_i = 1'b0;
    in_beat_i = '0;
    stim_state = 32'd66969;
    stall_enable = 1'b0;
    main_errors = 0;
    total_lines = 0;
    test_lines = 0;
    test_err_base = 0;
    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;

    for (i = 0; i < 6; i++) begin
      drive_line(0, 1 + rand_below(16), 1'b0, 1'b0, 64);
    end
    report_test("aligned lines");

    for (ofs = 1; ofs < 4; ofs++) begin
      for (i = 0; i < 3; i++) begin
        drive_line(ofs, 1 + rand_below(16), 1'b0, 1'b0, 64);
      end
    end
    report_test("offset lines");

    for (i = 0; i < 8; i++) begin
      drive_line(rand_below(4), 1 + rand_below(16), 1'b1, 1'b0, 64);
    end
    report_test("strobe holes");

    // output stalls outpace the input, so the FIFO runs full
    stall_enable = 1'b1;
    for (i = 0; i < 12; i++) begin
      drive_line(rand_below(4), 1 + rand_below(16), 1'b1, 1'b1, 64);
    end
    report_test("stalls and gaps");

    // line cut off after five input beats
    drive_line(2, 12, 1'b1, 1'b0, 5);
    repeat (3) @(negedge clk_i);
    reset_i = 1'b1;
    repeat (3) @(negedge clk_i);
    reset_i = 1'b0;
    @(posedge clk_i);
    check_out_valid(out_valid_o, main_errors);
    check_cmd_ready(cmd_ready_o, "after reset", main_errors);
    drive_line(3, 1 + rand_below(16), 1'b1, 1'b1, 64);
    drive_line(1, 1 + rand_below(16), 1'b1, 1'b1, 64);
    report_test("reset mid-line");
    stall_enable = 1'b0;

    $display("lines %0d, beats checked %0d, errors %0d", total_lines, beats_checked,
             cmp_errors + main_errors);
    if (cmp_errors + main_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- realign_tb_assert.sv
/*
 * concurrent checks on the stream handshakes of realign_top
 * output hold under stall, push ready against FIFO fill,
 * last qualified by valid, command ready during a line
 */

`default_nettype none

module realign_tb_assert (
  input logic                      clk_i,
  input logic                      reset_i,
  input logic                      cmd_valid_i,
  input logic                      cmd_ready_i,
  input logic                      in_valid_i,
  input logic                      in_ready_i,
  input logic                      fifo_valid_i,
  input logic                      fifo_ready_i,
  input logic                      out_valid_i,
  input realign_pkg::stream_beat_t out_beat_i,
  input logic                      out_ready_i
);

  import realign_pkg::*;

  logic [PTR_WIDTH:0] fill_q;
  logic               line_busy_q;

  // occupancy rebuilt from both FIFO handshakes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fill_q <= '0;
    end else begin
      fill_q <= fill_q + (PTR_WIDTH + 1)'(in_valid_i & in_ready_i)
                       - (PTR_WIDTH + 1)'(fifo_valid_i & fifo_ready_i);
    end
  end

  // line open from the command handshake up to the last output handshake
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      line_busy_q <= 1'b0;
    end else if (cmd_valid_i && cmd_ready_i) begin
      line_busy_q <= 1'b1;
    end else if (out_valid_i && out_ready_i && out_beat_i.last) begin
      line_busy_q <= 1'b0;
    end
  end

  stall_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_beat_i))
    else $error("output beat changed while stalled");

  full_no_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    in_ready_i |-> fill_q != (PTR_WIDTH + 1)'(FIFO_DEPTH))
    else $error("input ready high with the FIFO full");

  last_with_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    out_beat_i.last |-> out_valid_i)
    else $error("last bit set without output valid");

  busy_no_cmd: assert property (@(posedge clk_i) disable iff (reset_i)
    line_busy_q |-> !cmd_ready_i)
    else $error("command ready high during a line");

endmodule

bind realign_top realign_tb_assert assert_inst (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .cmd_valid_i  (cmd_valid_i),
  .cmd_ready_i  (cmd_ready_o),
  .in_valid_i   (in_valid_i),
  .in_ready_i   (in_ready_o),
  .fifo_valid_i (fifo_valid),
  .fifo_ready_i (fifo_ready),
  .out_valid_i  (out_valid_o),
  .out_beat_i   (out_beat_o),
  .out_ready_i  (out_ready_i)
);

`default_nettype wire

//--- realign_top.sv
/*
 * realign_top
 * input FIFO, line controller and source realigner
 */

`default_nettype none

module realign_top (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      cmd_valid_i,
  input  realign_pkg::realign_cmd_t cmd_i,
  output logic                      cmd_ready_o,
  input  logic                      in_valid_i,
  input  realign_pkg::stream_beat_t in_beat_i,
  output logic                      in_ready_o,
  output logic                      out_valid_o,
  output realign_pkg::stream_beat_t out_beat_o,
  input  logic                      out_ready_i
);

  import realign_pkg::*;

  logic          fifo_valid;
  logic          fifo_ready;
  stream_beat_t  fifo_beat;
  realign_ctrl_t line_ctrl;
  logic          line_active;
  logic          line_done;

  // decouples the memory side from the realigner
  stream_fifo fifo_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .push_valid_i (in_valid_i),
    .push_beat_i  (in_beat_i),
    .push_ready_o (in_ready_o),
    .pop_valid_o  (fifo_valid),
    .pop_beat_o   (fifo_beat),
    .pop_ready_i  (fifo_ready)
  );

  // counts beats taken from the FIFO
  realign_line_ctrl line_ctrl_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_i         (cmd_i),
    .cmd_ready_o   (cmd_ready_o),
    .beat_valid_i  (fifo_valid),
    .beat_ready_i  (fifo_ready),
    .line_done_i   (line_done),
    .line_active_o (line_active),
    .ctrl_o        (line_ctrl)
  );

  source_realign realigner_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .ctrl_i        (line_ctrl),
    .line_active_i (line_active),
    .in_valid_i    (fifo_valid),
    .in_beat_i     (fifo_beat),
    .in_ready_o    (fifo_ready),
    .out_valid_o   (out_valid_o),
    .out_beat_o    (out_beat_o),
    .out_ready_i   (out_ready_i),
    .line_done_o   (line_done)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the realign testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sim.f --top-module realign_tb \
  && ./obj_dir/Vrealign_tb > sim.log 2>&1 \
  || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "Everything OK" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- sim.f
realign_pkg.sv
stream_fifo.sv
realign_line_ctrl.sv
source_realign.sv
realign_top.sv
realign_tb_assert.sv
realign_tb.sv

//--- source_realign.sv
/*
 * source_realign
 * byte-rotating realigner for a line starting at a byte offset
 * merges held upper bytes of the previous beat with low bytes of the new one
 * strobes follow their bytes so holes in the input survive
 */

`default_nettype none

module source_realign (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  realign_pkg::realign_ctrl_t ctrl_i,
  input  logic                       line_active_i,
  input  logic                       in_valid_i,
  input  realign_pkg::stream_beat_t  in_beat_i,
  output logic                       in_ready_o,
  output logic                       out_valid_o,
  output realign_pkg::stream_beat_t  out_beat_o,
  input  logic                       out_ready_i,
  output logic                       line_done_o
);

  import realign_pkg::*;

  logic [DATA_WIDTH-1:0] hold_data_q;
  logic [STRB_WIDTH-1:0] hold_strb_q;
  logic [DATA_WIDTH-1:0] out_data_q;
  logic [STRB_WIDTH-1:0] out_strb_q;
  logic                  out_valid_q;
  logic                  out_last_q;
  logic                  tail_taken_q;
  logic [DATA_WIDTH-1:0] merged_data;
  logic [STRB_WIDTH-1:0] merged_strb;
  logic [OFS_WIDTH:0]    in_byte_shift;
  logic                  in_accept;
  logic                  out_drain;
  logic                  out_load;
  logic                  prime_only;

  assign out_drain = out_valid_q & out_ready_i;

  // stop taking beats once the final one of the line is in
  assign in_ready_o = line_active_i & ~tail_taken_q & (~out_valid_q | out_ready_i);
  assign in_accept  = in_valid_i & in_ready_o;

  // first beat of a misaligned line only primes the hold register
  assign prime_only = ctrl_i.realign & ctrl_i.first;
  assign out_load   = in_accept & ~prime_only;

  // low bytes of the incoming beat go above the held bytes
  assign in_byte_shift = (OFS_WIDTH + 1)'(STRB_WIDTH) - {1'b0, ctrl_i.rotation};

  always_comb begin
    if (ctrl_i.realign) begin
      merged_data = hold_data_q | (in_beat_i.data << {in_byte_shift, 3'b000});
      merged_strb = hold_strb_q | (in_beat_i.strb << in_byte_shift);
    end else begin
      merged_data = in_beat_i.data;
      merged_strb = in_beat_i.strb;
    end
  end

  // keep bytes from the rotation point up, moved down to byte 0
  always_ff @(posedge clk_i) begin
    if (in_accept) begin
      hold_data_q <= in_beat_i.data >> {ctrl_i.rotation, 3'b000};
      hold_strb_q <= in_beat_i.strb >> ctrl_i.rotation;
    end
  end

  // output word and strobe
  always_ff @(posedge clk_i) begin
    if (out_load) begin
      out_data_q <= merged_data;
      out_strb_q <= merged_strb;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_q  <= 1'b0;
      out_last_q   <= 1'b0;
      tail_taken_q <= 1'b0;
    end else begin
      if (out_load) begin
        out_valid_q <= 1'b1;
        out_last_q  <= ctrl_i.last;
      end else if (out_drain) begin
        out_valid_q <= 1'b0;
        out_last_q  <= 1'b0;
      end
      if (in_accept & ctrl_i.last) begin
        tail_taken_q <= 1'b1;
      end else if (line_done_o) begin
        tail_taken_q <= 1'b0;
      end
    end
  end

  assign out_valid_o = out_valid_q;
  assign line_done_o = out_drain & out_last_q;

  always_comb begin
    out_beat_o.data = out_data_q;
    out_beat_o.strb = out_strb_q;
    out_beat_o.last = out_last_q;
  end

endmodule

`default_nettype wire

//--- stream_fifo.sv
/*
 * stream_fifo
 * registered circular buffer of stream beats
 * valid/ready on the push and the pop side
 */

`default_nettype none

module stream_fifo (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      push_valid_i,
  input  realign_pkg::stream_beat_t push_beat_i,
  output logic                      push_ready_o,
  output logic                      pop_valid_o,
  output realign_pkg::stream_beat_t pop_beat_o,
  input  logic                      pop_ready_i
);

  import realign_pkg::*;

  stream_beat_t         mem_q [FIFO_DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr_q;
  logic [PTR_WIDTH-1:0] rd_ptr_q;
  logic [PTR_WIDTH:0]   count_q;
  logic                 push;
  logic                 pop;

  // ready only depends on the fill level, not on a pop in the same cycle
  assign push_ready_o = (count_q != (PTR_WIDTH + 1)'(FIFO_DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign pop_beat_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_beat_i;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire
